//--- verilog/mm_cfg_pkg.sv
// Geometry and number format constants of the matrix-multiply accelerator
package mm_cfg_pkg;

    // Systolic array is BLOCK_SIZE x BLOCK_SIZE cells
    localparam int BLOCK_SIZE   = 2;
    localparam int INNER_DIM    = 4;
    localparam int I_ROWS       = 4;
    localparam int W_COLS       = 4;
    localparam int CHUNK_SIZE   = 4;

    // Signed Q8.8 elements
    localparam int ELEM_WIDTH   = 16;
    localparam int FRAC_WIDTH   = 8;
    localparam int ELEM_MAX     = 2**(ELEM_WIDTH-1) - 1;
    localparam int ELEM_MIN     = -(2**(ELEM_WIDTH-1));

    localparam int TILE_ROWS    = I_ROWS / BLOCK_SIZE;
    localparam int TILE_COLS    = W_COLS / BLOCK_SIZE;

    // Skew cycles between the last feed and the final sum in the far corner cell
    localparam int DRAIN_CYCLES = 2*(BLOCK_SIZE-1) + 1;

    localparam int OUT_CREDITS  = 4;

endpackage

//--- verilog/mm_types_pkg.sv
// Element, accumulator, memory word and result types of the accelerator
package mm_types_pkg;

    typedef logic signed [mm_cfg_pkg::ELEM_WIDTH-1:0]   elem_t;
    typedef logic signed [2*mm_cfg_pkg::ELEM_WIDTH-1:0] acc_t;

    // Element 0 sits in the low bits
    typedef logic [mm_cfg_pkg::CHUNK_SIZE*mm_cfg_pkg::ELEM_WIDTH-1:0] chunk_t;
    typedef logic [mm_cfg_pkg::CHUNK_SIZE-1:0]                        chunk_mask_t;

    typedef logic [$clog2(mm_cfg_pkg::INNER_DIM)-1:0] bram_addr_t;
    typedef logic [$clog2(mm_cfg_pkg::I_ROWS)-1:0]    mat_idx_t;

    typedef struct packed {
        logic        en;
        bram_addr_t  addr;
        chunk_mask_t mask;
        chunk_t      data;
    } chunk_write_t;

    typedef struct packed {
        mat_idx_t row;
        mat_idx_t col;
        elem_t    value;
    } result_t;

endpackage

//--- verilog/chunk_bram.sv
// Chunk memory with one element-masked write port and one registered read port
`timescale 1ns/1ps

module chunk_bram (
    input  logic                       clk,
    input  mm_types_pkg::chunk_write_t wr,
    input  logic                       rd_en,
    input  mm_types_pkg::bram_addr_t   rd_addr,
    output mm_types_pkg::chunk_t       rd_data
);

    mm_types_pkg::chunk_t mem [mm_cfg_pkg::INNER_DIM];

    // Unmasked elements keep their old value
    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            for (int e = 0; e < mm_cfg_pkg::CHUNK_SIZE; e++)
            begin
                if (wr.mask[e])
                begin
                    mem[wr.addr][e*mm_cfg_pkg::ELEM_WIDTH +: mm_cfg_pkg::ELEM_WIDTH] <=
                        wr.data[e*mm_cfg_pkg::ELEM_WIDTH +: mm_cfg_pkg::ELEM_WIDTH];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- verilog/mac_pe.sv
// Q8.8 multiply-accumulate cell passing its operands right and down
`timescale 1ns/1ps

module mac_pe (
    input  logic                clk,
    input  logic                arst_n,
    input  mm_types_pkg::elem_t a_in,
    input  mm_types_pkg::elem_t b_in,
    input  logic                valid_in,
    input  logic                clear,
    output mm_types_pkg::elem_t a_out,
    output mm_types_pkg::elem_t b_out,
    output logic                valid_out,
    output mm_types_pkg::acc_t  acc
);

    mm_types_pkg::acc_t product;

    // Sign-extend before multiplying to keep the full Q16.16 product
    assign product = mm_types_pkg::acc_t'(a_in) * mm_types_pkg::acc_t'(b_in);

    always_ff @(posedge clk)
    begin
        a_out <= a_in;
        b_out <= b_in;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_out <= 1'b0;
            acc       <= '0;
        end
        else
        begin
            valid_out <= valid_in;
            // Clear wins over a product arriving in the same cycle
            if (clear)
                acc <= '0;
            else if (valid_in)
                acc <= acc + product;
        end
    end

endmodule

//--- verilog/systolic_array.sv
// Output-stationary grid of MAC cells with skewed row and column feeding
`timescale 1ns/1ps

module systolic_array (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  mm_types_pkg::elem_t [mm_cfg_pkg::BLOCK_SIZE-1:0]    row_ops,
    input  mm_types_pkg::elem_t [mm_cfg_pkg::BLOCK_SIZE-1:0]    col_ops,
    input  logic                                                feed_valid,
    input  logic                                                acc_clear,
    output mm_types_pkg::acc_t [mm_cfg_pkg::BLOCK_SIZE-1:0][mm_cfg_pkg::BLOCK_SIZE-1:0] acc
);

    localparam int BS = mm_cfg_pkg::BLOCK_SIZE;

    mm_types_pkg::elem_t [BS-1:0] row_skew;
    mm_types_pkg::elem_t [BS-1:0] col_skew;
    logic [BS-1:0]                valid_skew;

    // Operands leaving each cell towards its neighbours
    mm_types_pkg::elem_t a_link [BS][BS];
    mm_types_pkg::elem_t b_link [BS][BS];
    logic                v_link [BS][BS];

    // Row i and column i enter i cycles late
    for (genvar i = 0; i < BS; i++)
    begin : g_skew
        if (i == 0)
        begin : g_direct
            assign row_skew[i]   = row_ops[i];
            assign col_skew[i]   = col_ops[i];
            assign valid_skew[i] = feed_valid;
        end
        else
        begin : g_delay
            mm_types_pkg::elem_t a_pipe [1:i];
            mm_types_pkg::elem_t b_pipe [1:i];
            logic [i:1]          v_pipe;

            always_ff @(posedge clk)
            begin
                a_pipe[1] <= row_ops[i];
                b_pipe[1] <= col_ops[i];
                for (int d = 2; d <= i; d++)
                begin
                    a_pipe[d] <= a_pipe[d-1];
                    b_pipe[d] <= b_pipe[d-1];
                end
            end

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                    v_pipe <= '0;
                else
                begin
                    v_pipe[1] <= feed_valid;
                    for (int d = 2; d <= i; d++)
                        v_pipe[d] <= v_pipe[d-1];
                end
            end

            assign row_skew[i]   = a_pipe[i];
            assign col_skew[i]   = b_pipe[i];
            assign valid_skew[i] = v_pipe[i];
        end
    end

    for (genvar i = 0; i < BS; i++)
    begin : g_row
        for (genvar j = 0; j < BS; j++)
        begin : g_col
            mm_types_pkg::elem_t a_in;
            mm_types_pkg::elem_t b_in;
            logic                v_in;

            // Left column takes the skewed rows, the rest chain from the left
            if (j == 0)
            begin : g_left_edge
                assign a_in = row_skew[i];
                assign v_in = valid_skew[i];
            end
            else
            begin : g_left_chain
                assign a_in = a_link[i][j-1];
                assign v_in = v_link[i][j-1];
            end

            if (i == 0)
            begin : g_top_edge
                assign b_in = col_skew[j];
            end
            else
            begin : g_top_chain
                assign b_in = b_link[i-1][j];
            end

            mac_pe pe_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .a_in      (a_in),
                .b_in      (b_in),
                .valid_in  (v_in),
                .clear     (acc_clear),
                .a_out     (a_link[i][j]),
                .b_out     (b_link[i][j]),
                .valid_out (v_link[i][j]),
                .acc       (acc[i][j])
            );
        end
    end

endmodule

//--- verilog/mm_controller.sv
// Tile sequencer that loads operands, feeds the array and streams scaled results
`timescale 1ns/1ps

module mm_controller (
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic                                             start,
    output logic                                             busy,
    output logic                                             done,
    output logic                                             rd_en,
    output mm_types_pkg::bram_addr_t                         i_rd_addr,
    output mm_types_pkg::bram_addr_t                         w_rd_addr,
    input  mm_types_pkg::chunk_t                             i_rd_data,
    input  mm_types_pkg::chunk_t                             w_rd_data,
    output mm_types_pkg::elem_t [mm_cfg_pkg::BLOCK_SIZE-1:0] row_ops,
    output mm_types_pkg::elem_t [mm_cfg_pkg::BLOCK_SIZE-1:0] col_ops,
    output logic                                             feed_valid,
    output logic                                             acc_clear,
    input  mm_types_pkg::acc_t [mm_cfg_pkg::BLOCK_SIZE-1:0][mm_cfg_pkg::BLOCK_SIZE-1:0] acc,
    output mm_types_pkg::result_t                            res,
    output logic                                             res_valid,
    input  logic                                             res_credit
);

    localparam int BS = mm_cfg_pkg::BLOCK_SIZE;
    localparam int EW = mm_cfg_pkg::ELEM_WIDTH;

    typedef enum logic [2:0] {IDLE, LOAD, FEED, DRAIN, EMIT, FINISH} state_t;
    typedef logic [$clog2(BS)-1:0]                        blk_idx_t;
    typedef logic [$clog2(BS*BS)-1:0]                     emit_idx_t;
    typedef logic [$clog2(mm_cfg_pkg::INNER_DIM+1)-1:0]   step_t;
    typedef logic [$clog2(mm_cfg_pkg::OUT_CREDITS+1)-1:0] credit_t;

    state_t                        state;
    step_t                         step;
    mm_types_pkg::mat_idx_t        tile_r;
    mm_types_pkg::mat_idx_t        tile_c;
    emit_idx_t                     emit_idx;
    blk_idx_t                      emit_r;
    blk_idx_t                      emit_c;
    credit_t                       credits;
    logic                          last_tile;
    logic                          last_emit;
    mm_types_pkg::chunk_t [BS-1:0] i_ops;
    mm_types_pkg::chunk_t [BS-1:0] w_ops;

    // Q16.16 to Q8.8 by flooring shift and clipping
    function automatic mm_types_pkg::elem_t scale_sat(input mm_types_pkg::acc_t value);
        mm_types_pkg::acc_t shifted;
        shifted = value >>> mm_cfg_pkg::FRAC_WIDTH;
        if (shifted > mm_cfg_pkg::ELEM_MAX)
            return mm_types_pkg::elem_t'(mm_cfg_pkg::ELEM_MAX);
        else if (shifted < mm_cfg_pkg::ELEM_MIN)
            return mm_types_pkg::elem_t'(mm_cfg_pkg::ELEM_MIN);
        return mm_types_pkg::elem_t'(shifted);
    endfunction

    assign busy  = (state != IDLE) && (state != FINISH);
    assign done  = (state == FINISH);

    // Row r of I and column c of W are read together
    assign rd_en     = (state == LOAD) && (step < BS);
    assign i_rd_addr = mm_types_pkg::bram_addr_t'(tile_r * BS + step);
    assign w_rd_addr = mm_types_pkg::bram_addr_t'(tile_c * BS + step);

    assign last_tile = (tile_r == mm_cfg_pkg::TILE_ROWS - 1) &&
                       (tile_c == mm_cfg_pkg::TILE_COLS - 1);
    assign last_emit = (emit_idx == BS*BS - 1);

    // Results in row-major order within the tile
    assign emit_r    = blk_idx_t'(emit_idx / BS);
    assign emit_c    = blk_idx_t'(emit_idx % BS);
    assign res.row   = mm_types_pkg::mat_idx_t'(tile_r * BS + emit_r);
    assign res.col   = mm_types_pkg::mat_idx_t'(tile_c * BS + emit_c);
    assign res.value = scale_sat(acc[emit_r][emit_c]);
    assign res_valid = (state == EMIT) && (credits != '0);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            step     <= '0;
            tile_r   <= '0;
            tile_c   <= '0;
            emit_idx <= '0;
        end
        else
        begin
            case (state)
                IDLE, FINISH:
                begin
                    state <= start ? LOAD : IDLE;
                    step  <= '0;
                    if (start)
                    begin
                        tile_r <= '0;
                        tile_c <= '0;
                    end
                end
                LOAD:
                begin
                    // One extra cycle collects the last read word
                    step  <= (step == BS) ? '0 : step + 1'b1;
                    state <= (step == BS) ? FEED : LOAD;
                end
                FEED:
                begin
                    step  <= (step == mm_cfg_pkg::INNER_DIM - 1) ? '0 : step + 1'b1;
                    state <= (step == mm_cfg_pkg::INNER_DIM - 1) ? DRAIN : FEED;
                end
                DRAIN:
                begin
                    step     <= (step == mm_cfg_pkg::DRAIN_CYCLES - 1) ? '0 : step + 1'b1;
                    state    <= (step == mm_cfg_pkg::DRAIN_CYCLES - 1) ? EMIT : DRAIN;
                    emit_idx <= '0;
                end
                EMIT:
                begin
                    // Without credits everything holds
                    if (res_valid)
                    begin
                        emit_idx <= emit_idx + 1'b1;
                        if (last_emit && last_tile)
                            state <= FINISH;
                        else if (last_emit)
                        begin
                            state <= LOAD;
                            if (tile_c == mm_cfg_pkg::TILE_COLS - 1)
                            begin
                                tile_c <= '0;
                                tile_r <= tile_r + 1'b1;
                            end
                            else
                                tile_c <= tile_c + 1'b1;
                        end
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        // Read data lags its address by one cycle
        if (state == LOAD && step != '0)
        begin
            i_ops[step-1] <= i_rd_data;
            w_ops[step-1] <= w_rd_data;
        end
        if (state == FEED)
        begin
            for (int b = 0; b < BS; b++)
            begin
                row_ops[b] <= i_ops[b][step*EW +: EW];
                col_ops[b] <= w_ops[b][step*EW +: EW];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            feed_valid <= 1'b0;
            acc_clear  <= 1'b0;
            credits    <= credit_t'(mm_cfg_pkg::OUT_CREDITS);
        end
        else
        begin
            feed_valid <= (state == FEED);
            acc_clear  <= (state == LOAD);
            credits    <= credits - credit_t'(res_valid) + credit_t'(res_credit);
        end
    end

endmodule

//--- verilog/mm_top.sv
// Matrix-multiply accelerator top with operand memories, sequencer and array
`timescale 1ns/1ps

module mm_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  mm_types_pkg::chunk_write_t w_wr,
    input  mm_types_pkg::chunk_write_t i_wr,
    output mm_types_pkg::result_t      res,
    output logic                       res_valid,
    input  logic                       res_credit,
    output logic                       busy,
    output logic                       done
);

    logic                                             rd_en;
    mm_types_pkg::bram_addr_t                         i_rd_addr;
    mm_types_pkg::bram_addr_t                         w_rd_addr;
    mm_types_pkg::chunk_t                             i_rd_data;
    mm_types_pkg::chunk_t                             w_rd_data;
    mm_types_pkg::elem_t [mm_cfg_pkg::BLOCK_SIZE-1:0] row_ops;
    mm_types_pkg::elem_t [mm_cfg_pkg::BLOCK_SIZE-1:0] col_ops;
    logic                                             feed_valid;
    logic                                             acc_clear;
    mm_types_pkg::acc_t [mm_cfg_pkg::BLOCK_SIZE-1:0][mm_cfg_pkg::BLOCK_SIZE-1:0] acc;

    // Columns of W, one per word
    chunk_bram w_bram (
        .clk     (clk),
        .wr      (w_wr),
        .rd_en   (rd_en),
        .rd_addr (w_rd_addr),
        .rd_data (w_rd_data)
    );

    // Rows of I, one per word
    chunk_bram i_bram (
        .clk     (clk),
        .wr      (i_wr),
        .rd_en   (rd_en),
        .rd_addr (i_rd_addr),
        .rd_data (i_rd_data)
    );

    mm_controller ctrl_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .rd_en      (rd_en),
        .i_rd_addr  (i_rd_addr),
        .w_rd_addr  (w_rd_addr),
        .i_rd_data  (i_rd_data),
        .w_rd_data  (w_rd_data),
        .row_ops    (row_ops),
        .col_ops    (col_ops),
        .feed_valid (feed_valid),
        .acc_clear  (acc_clear),
        .acc        (acc),
        .res        (res),
        .res_valid  (res_valid),
        .res_credit (res_credit)
    );

    systolic_array array_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .row_ops    (row_ops),
        .col_ops    (col_ops),
        .feed_valid (feed_valid),
        .acc_clear  (acc_clear),
        .acc        (acc)
    );

endmodule

//--- tests/mm_assertions.sv
// Output protocol checks on the tile sequencer
`timescale 1ns/1ps

module mm_assertions (
    input logic                                              clk,
    input logic                                              arst_n,
    input logic                                              busy,
    input logic                                              done,
    input logic                                              res_valid,
    input logic                                              res_credit,
    input logic [$clog2(mm_cfg_pkg::OUT_CREDITS+1)-1:0]      credits
);

    // Results sent and not yet paid back by the consumer
    logic [$clog2(mm_cfg_pkg::OUT_CREDITS+1)-1:0] in_flight;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            in_flight <= '0;
        else
            in_flight <= in_flight + res_valid - res_credit;
    end

    // A result only leaves while the consumer still has room
    valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> (in_flight < mm_cfg_pkg::OUT_CREDITS))
        else $error("res_valid asserted with no credits left");

    credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= mm_cfg_pkg::OUT_CREDITS)
        else $error("credit count above the consumer grant");

    done_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    valid_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> busy)
        else $error("res_valid asserted while not busy");

endmodule

bind mm_controller mm_assertions chk_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .busy       (busy),
    .done       (done),
    .res_valid  (res_valid),
    .res_credit (res_credit),
    .credits    (credits)
);

//--- tests/mm_tb.sv
// Directed testbench for the matrix-multiply accelerator with a reference model
`timescale 1ns/1ps

module mm_tb;

    localparam int EW         = mm_cfg_pkg::ELEM_WIDTH;
    localparam int BS         = mm_cfg_pkg::BLOCK_SIZE;
    localparam int N_RESULTS  = mm_cfg_pkg::I_ROWS * mm_cfg_pkg::W_COLS;
    localparam int MAX_CYCLES = 6 * 400;

    logic                       clk;
    logic                       arst_n;
    logic                       start;
    mm_types_pkg::chunk_write_t w_wr;
    mm_types_pkg::chunk_write_t i_wr;
    mm_types_pkg::result_t      res;
    logic                       res_valid;
    logic                       res_credit;
    logic                       busy;
    logic                       done;

    int                    seed;
    int                    cycle_cnt;
    int                    error_cnt;
    int                    check_cnt;
    int                    test_cnt;
    int                    credit_delay;
    logic                  credit_hold;
    int                    credit_due[$];
    mm_types_pkg::result_t got[$];
    // Model copies of I (row, col) and W (row, col)
    int                    i_mat[4][4];
    int                    w_mat[4][4];

    mm_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .w_wr       (w_wr),
        .i_wr       (i_wr),
        .res        (res),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run length limit
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the run did not complete within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Collector samples mid-cycle and schedules a credit per result
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (arst_n === 1'b1 && res_valid === 1'b1)
            begin
                got.push_back(res);
                credit_due.push_back(cycle_cnt + credit_delay);
            end
        end
    end

    initial
    begin
        res_credit = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            if (!credit_hold && credit_due.size() != 0 && credit_due[0] <= cycle_cnt)
            begin
                res_credit = 1'b1;
                void'(credit_due.pop_front());
            end
            else
                res_credit = 1'b0;
        end
    end

    task automatic compare_result(input string name, input mm_types_pkg::result_t actual,
                                  input mm_types_pkg::result_t expected);
        check_cnt++;
        if (actual !== expected)
        begin
            $display("** Error: %s got row %h col %h value %h, expected row %h col %h value %h",
                     name, actual.row, actual.col, actual.value,
                     expected.row, expected.col, expected.value);
            error_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        check_cnt++;
        if (actual !== expected)
        begin
            $display("** Error: %s got %h expected %h", name, actual, expected);
            error_cnt++;
        end
    endtask

    function automatic mm_types_pkg::elem_t pick_value(input int mode, input int r, input int c,
                                                       input bit is_w);
        if (mode == 0)
        begin
            if (is_w)
                return (r == c) ? mm_types_pkg::elem_t'(16'h0100) : '0;
            return mm_types_pkg::elem_t'((r * 4 + c) * 97 - 700);
        end
        if (mode == 1)
            return mm_types_pkg::elem_t'($random(seed) % 1024);
        // Magnitude 64.0 with signs by row of I and column of W
        return (((is_w ? c : r) % 2) != 0) ? mm_types_pkg::elem_t'(-16384)
                                           : mm_types_pkg::elem_t'(16384);
    endfunction

    // Exact sum, floor shift, then clip to 16 bits
    function automatic mm_types_pkg::elem_t model_value(input int r, input int c);
        longint sum;
        longint shifted;
        sum = 0;
        for (int k = 0; k < mm_cfg_pkg::INNER_DIM; k++)
            sum += longint'(i_mat[r][k]) * longint'(w_mat[k][c]);
        shifted = sum >>> mm_cfg_pkg::FRAC_WIDTH;
        if (shifted > 32767)
            shifted = 32767;
        else if (shifted < -32768)
            shifted = -32768;
        return mm_types_pkg::elem_t'(shifted);
    endfunction

    // Unmasked lanes carry filler that must not land in memory
    task automatic write_elems(input bit to_w, input int addr, input mm_types_pkg::chunk_mask_t mask,
                               input mm_types_pkg::chunk_t vals);
        mm_types_pkg::chunk_write_t wr;
        mm_types_pkg::elem_t        v;
        wr.en   = 1'b1;
        wr.addr = mm_types_pkg::bram_addr_t'(addr);
        wr.mask = mask;
        wr.data = vals;
        for (int e = 0; e < mm_cfg_pkg::CHUNK_SIZE; e++)
        begin
            v = vals[e*EW +: EW];
            if (!mask[e])
                wr.data[e*EW +: EW] = 16'h5A5A;
            else if (to_w)
                w_mat[e][addr] = v;
            else
                i_mat[addr][e] = v;
        end
        @(posedge clk);
        #2;
        if (to_w)
            w_wr = wr;
        else
            i_wr = wr;
        @(posedge clk);
        #2;
        w_wr = '0;
        i_wr = '0;
    endtask

    task automatic load_matrices(input int mode);
        mm_types_pkg::chunk_t i_word;
        mm_types_pkg::chunk_t w_word;
        for (int a = 0; a < 4; a++)
        begin
            for (int e = 0; e < 4; e++)
            begin
                i_word[e*EW +: EW] = pick_value(mode, a, e, 1'b0);
                w_word[e*EW +: EW] = pick_value(mode, e, a, 1'b1);
            end
            write_elems(1'b0, a, 4'hF, i_word);
            write_elems(1'b1, a, 4'hF, w_word);
        end
    endtask

    task automatic pulse_start();
        got.delete();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        compare_bit("busy", busy, 1'b1);
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (done !== 1'b1)
            @(negedge clk);
    endtask

    // Tiles in row-major order, results row-major inside each tile
    task automatic check_results(input bit identity);
        mm_types_pkg::result_t expected;
        int                    n;
        int                    r;
        int                    c;
        check_cnt++;
        if (got.size() != N_RESULTS)
        begin
            $display("Result count wrong: received %0d of %0d results", got.size(), N_RESULTS);
            error_cnt++;
        end
        n = 0;
        for (int tr = 0; tr < mm_cfg_pkg::TILE_ROWS; tr++)
            for (int tc = 0; tc < mm_cfg_pkg::TILE_COLS; tc++)
                for (int e = 0; e < BS * BS; e++)
                begin
                    r = tr * BS + e / BS;
                    c = tc * BS + e % BS;
                    expected.row   = mm_types_pkg::mat_idx_t'(r);
                    expected.col   = mm_types_pkg::mat_idx_t'(c);
                    expected.value = identity ? mm_types_pkg::elem_t'(i_mat[r][c])
                                              : model_value(r, c);
                    if (n < got.size())
                        compare_result("res", got[n], expected);
                    n++;
                end
        // Let outstanding credits return before the next test
        while (credit_due.size() != 0)
            @(negedge clk);
    endtask

    task automatic report_test(input string name, input int base);
        test_cnt++;
        $display("Test %0d %-14s %0d error(s)", test_cnt, name, error_cnt - base);
    endtask

    task automatic test_reset_state();
        int base;
        base = error_cnt;
        compare_bit("busy", busy, 1'b0);
        compare_bit("done", done, 1'b0);
        compare_bit("res_valid", res_valid, 1'b0);
        repeat (10) @(negedge clk);
        check_cnt++;
        if (got.size() != 0)
        begin
            $display("Results appeared without a start: %0d seen", got.size());
            error_cnt++;
        end
        report_test("reset_state", base);
    endtask

    task automatic test_identity();
        int base;
        base = error_cnt;
        credit_delay = 1;
        load_matrices(0);
        pulse_start();
        wait_done();
        check_results(1'b1);
        report_test("identity", base);
    endtask

    task automatic test_random();
        int base;
        base = error_cnt;
        credit_delay = 3;
        load_matrices(1);
        pulse_start();
        wait_done();
        check_results(1'b0);
        report_test("random", base);
    endtask

    task automatic test_saturation();
        int base;
        base = error_cnt;
        credit_delay = 0;
        load_matrices(2);
        pulse_start();
        wait_done();
        check_results(1'b0);
        report_test("saturation", base);
    endtask

    task automatic test_masked_writes();
        mm_types_pkg::chunk_t vals;
        int                   base;
        base = error_cnt;
        credit_delay = 6;
        load_matrices(1);
        for (int e = 0; e < 4; e++)
            vals[e*EW +: EW] = pick_value(1, 0, e, 1'b0);
        write_elems(1'b0, 1, 4'b0101, vals);
        write_elems(1'b1, 2, 4'b1000, ~vals);
        write_elems(1'b1, 0, 4'b0010, {vals[31:0], vals[63:32]});
        pulse_start();
        wait_done();
        check_results(1'b0);
        report_test("masked_writes", base);
    endtask

    task automatic test_back_pressure();
        int base;
        base = error_cnt;
        credit_delay = 0;
        credit_hold = 1'b1;
        pulse_start();
        repeat (50) @(negedge clk);
        check_cnt++;
        if (got.size() > mm_cfg_pkg::OUT_CREDITS)
        begin
            $display("Too many results without credit: %0d seen", got.size());
            error_cnt++;
        end
        compare_bit("busy", busy, 1'b1);
        credit_hold = 1'b0;
        wait_done();
        check_results(1'b0);
        report_test("back_pressure", base);
    endtask

    initial
    begin
        seed         = 68;
        error_cnt    = 0;
        check_cnt    = 0;
        test_cnt     = 0;
        credit_delay = 0;
        credit_hold  = 1'b0;
        arst_n       = 1'b0;
        start        = 1'b0;
        w_wr         = '0;
        i_wr         = '0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        test_reset_state();
        test_identity();
        test_random();
        test_saturation();
        test_masked_writes();
        test_back_pressure();

        $display("Tests: %0d  Checks: %0d  Errors: %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- mm_accel.f
verilog/mm_cfg_pkg.sv
verilog/mm_types_pkg.sv
verilog/chunk_bram.sv
verilog/mac_pe.sv
verilog/systolic_array.sv
verilog/mm_controller.sv
verilog/mm_top.sv
tests/mm_assertions.sv
tests/mm_tb.sv

//--- Bender.yml
package:
  name: mm_accel

sources:
  - verilog/mm_cfg_pkg.sv
  - verilog/mm_types_pkg.sv
  - verilog/chunk_bram.sv
  - verilog/mac_pe.sv
  - verilog/systolic_array.sv
  - verilog/mm_controller.sv
  - verilog/mm_top.sv
  - target: test
    files:
      - tests/mm_assertions.sv
      - tests/mm_tb.sv
